//--- all.f
+incdir+verilog
+incdir+bench
verilog/softmax_data_pkg.sv
verilog/softmax_ctrl_pkg.sv
verilog/softmax_exp_loader.sv
verilog/softmax_divider.sv
verilog/softmax_emitter.sv
verilog/vector_softmax.sv
bench/vector_softmax_tb.sv

//--- bench/softmax_ref.svh
//////////////////////////////
// Reference model, integer math; rows of at most SM_MAX_LEN elements
//////////////////////////////
`ifndef SOFTMAX_REF_SVH
`define SOFTMAX_REF_SVH

`include "softmax_consts.svh"

// 2 ** element as a plain integer
function automatic int elem_exp(input int elem);
  return 1 << elem;
endfunction

// Sum of exponentials over the first len elements
function automatic int row_sum(input int elems [`SM_MAX_LEN], input int len);
  int sum;
  int i;
  sum = 0;
  for (i = 0; i < len; i++) begin
    sum += elem_exp(elems[i]);
  end
  return sum;
endfunction

// Exponential times 4096 over the row sum, rounded down
function automatic int softmax_prob(input int elem, input int sum);
  return (elem_exp(elem) * 4096) / sum;
endfunction

// Row end flag for element idx
function automatic bit is_row_end(input int idx, input int len);
  return idx == len - 1;
endfunction

`endif

//--- bench/vector_softmax_tb.sv
//////////////////////////////
// Sends a row only after the previous data_out_vector_enable
// Watchdog limit scales with the element count of all tests
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "softmax_consts.svh"

module vector_softmax_tb;

  import softmax_data_pkg::*;

  `include "softmax_ref.svh"

  logic  CLK;
  logic  RST;
  logic  start;
  row_t  size_in;
  len_t  length_in;
  elem_t data_in;
  logic  data_in_vector_enable;
  logic  data_in_scalar_enable;
  prob_t data_out;
  logic  data_out_scalar_enable;
  logic  data_out_vector_enable;
  logic  ready;

  integer seed;
  // Error counts kept apart per process
  int chk_err;
  int main_err;
  int ready_total;
  int pass_tests;
  int fail_tests;

  // Expected results in output order
  int exp_val_q [$];
  bit row_end_q [$];
  bit run_end_q [$];

  // Checker scratch
  int exp_val;
  bit exp_row_end;
  bit exp_run_end;

  vector_softmax u_dut (
    .CLK                    (CLK),
    .RST                    (RST),
    .start                  (start),
    .size_in                (size_in),
    .length_in              (length_in),
    .data_in                (data_in),
    .data_in_vector_enable  (data_in_vector_enable),
    .data_in_scalar_enable  (data_in_scalar_enable),
    .data_out               (data_out),
    .data_out_scalar_enable (data_out_scalar_enable),
    .data_out_vector_enable (data_out_vector_enable),
    .ready                  (ready)
  );

  // 10 ns clock
  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  //////////////////////////////
  // Comparing process
  //////////////////////////////
  always @(negedge CLK) begin
    if (RST) begin
      // Results still pending are dropped by reset
      exp_val_q.delete();
      row_end_q.delete();
      run_end_q.delete();
    end else if (data_out_scalar_enable) begin
      assert (exp_val_q.size() > 0) else begin
        $display("Result came out with no expected value pending");
        chk_err++;
      end
      if (exp_val_q.size() > 0) begin
        exp_val     = exp_val_q.pop_front();
        exp_row_end = row_end_q.pop_front();
        exp_run_end = run_end_q.pop_front();
        assert (data_out == prob_t'(exp_val)) else begin
          $display("Error: data_out got %h expected %h", data_out, prob_t'(exp_val));
          chk_err++;
        end
        assert (data_out_vector_enable == exp_row_end) else begin
          $display("Error: data_out_vector_enable got %h expected %h",
                   data_out_vector_enable, exp_row_end);
          chk_err++;
        end
        assert (ready == exp_run_end) else begin
          $display("Error: ready got %h expected %h", ready, exp_run_end);
          chk_err++;
        end
      end
      if (ready) begin
        ready_total++;
      end
    end else begin
      // End strobes only ride on a result
      assert (!data_out_vector_enable && !ready) else begin
        $display("Row or run end strobe came without data_out_scalar_enable");
        chk_err++;
      end
    end
  end

  // Caller sits on a falling edge; first row may follow next cycle
  task automatic start_run(input int size, input int len);
    start     = 1'b1;
    size_in   = row_t'(size);
    length_in = len_t'(len);
    @(negedge CLK);
    start = 1'b0;
  endtask

  // Queue the expected values, then drive one element per cycle
  task automatic send_row(input int len, input bit uniform, input int fill,
                          input bit last_row);
    int elems [`SM_MAX_LEN];
    int sum;
    int i;
    for (i = 0; i < `SM_MAX_LEN; i++) begin
      elems[i] = 0;
    end
    for (i = 0; i < len; i++) begin
      elems[i] = uniform ? fill : $unsigned($random(seed)) % 16;
    end
    sum = row_sum(elems, len);
    for (i = 0; i < len; i++) begin
      exp_val_q.push_back(softmax_prob(elems[i], sum));
      row_end_q.push_back(is_row_end(i, len));
      run_end_q.push_back(last_row && is_row_end(i, len));
    end
    for (i = 0; i < len; i++) begin
      data_in               = elem_t'(elems[i]);
      data_in_vector_enable = (i == 0);
      data_in_scalar_enable = (i != 0);
      @(negedge CLK);
    end
    data_in_vector_enable = 1'b0;
    data_in_scalar_enable = 1'b0;
  endtask

  // Ends one cycle after the row's last result
  task automatic wait_row_end();
    do begin
      @(negedge CLK);
    end while (!data_out_vector_enable);
    @(negedge CLK);
  endtask

  // Outputs must be low while reset is held
  task automatic check_reset_outputs();
    assert (!ready && !data_out_scalar_enable && !data_out_vector_enable) else begin
      $display("Error: in reset ready=%h data_out_scalar_enable=%h data_out_vector_enable=%h",
               ready, data_out_scalar_enable, data_out_vector_enable);
      main_err++;
    end
  endtask

  task automatic run_softmax(input int size, input int len, input bit uniform,
                             input int fill);
    int ready_base;
    int r;
    ready_base = ready_total;
    start_run(size, len);
    for (r = 0; r < size; r++) begin
      send_row(len, uniform, fill, r == size - 1);
      wait_row_end();
    end
    assert (ready_total - ready_base == 1) else begin
      $display("ready pulsed %0d times in one run instead of once",
               ready_total - ready_base);
      main_err++;
    end
    assert (exp_val_q.size() == 0) else begin
      $display("%0d expected results never came out", exp_val_q.size());
      main_err++;
    end
  endtask

  task automatic finish_test(input int num, input string name, input int err_base);
    int errs;
    errs = chk_err + main_err - err_base;
    if (errs == 0) begin
      pass_tests++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      fail_tests++;
      $display("Test %0d %s: %0d errors", num, name, errs);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int t3_size [3];
    int t3_len [3];
    int total_elems;
    int limit;
    int k;
    int err_base;
    seed                  = 32'h3633_d7ec;
    RST                   = 1'b1;
    start                 = 1'b0;
    size_in               = '0;
    length_in             = '0;
    data_in               = '0;
    data_in_vector_enable = 1'b0;
    data_in_scalar_enable = 1'b0;
    // Random run shapes picked up front for the watchdog
    total_elems = 1 + 12 + 3 + 30 + 32 + 21;
    for (k = 0; k < 3; k++) begin
      t3_size[k]  = 2 + $unsigned($random(seed)) % 4;
      t3_len[k]   = 1 + $unsigned($random(seed)) % 16;
      total_elems += t3_size[k] * t3_len[k];
    end
    limit = total_elems * 40 + 500;
    fork
      begin
        repeat (limit) @(posedge CLK);
        $display("Timeout after %0d cycles, the DUT stopped producing results", limit);
        $display("TEST FAILED");
        $finish;
      end
    join_none
    repeat (16) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Single element always gives one
    err_base = chk_err + main_err;
    run_softmax(1, 1, 1'b1, $unsigned($random(seed)) % 16);
    finish_test(1, "single element row", err_base);

    err_base = chk_err + main_err;
    run_softmax(2, 6, 1'b1, 9);
    run_softmax(1, 3, 1'b1, 15);
    finish_test(2, "uniform rows", err_base);

    err_base = chk_err + main_err;
    for (k = 0; k < 3; k++) begin
      run_softmax(t3_size[k], t3_len[k], 1'b0, 0);
    end
    finish_test(3, "random rows", err_base);

    err_base = chk_err + main_err;
    run_softmax(3, 4, 1'b0, 0);
    run_softmax(2, 9, 1'b0, 0);
    finish_test(4, "back to back runs", err_base);

    // Abort on the second row's last result, two rows still to come
    err_base = chk_err + main_err;
    start_run(4, 8);
    send_row(8, 1'b0, 0, 1'b0);
    wait_row_end();
    send_row(8, 1'b0, 0, 1'b0);
    do begin
      @(negedge CLK);
    end while (!data_out_vector_enable);
    RST = 1'b1;
    // Asynchronous clear, strobes drop at once
    #1;
    check_reset_outputs();
    repeat (3) begin
      @(negedge CLK);
      check_reset_outputs();
    end
    RST = 1'b0;
    @(negedge CLK);
    run_softmax(3, 7, 1'b0, 0);
    finish_test(5, "reset mid-run", err_base);

    $display("Tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && chk_err + main_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the softmax testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module vector_softmax_tb -o vector_softmax_sim

./obj_dir/vector_softmax_sim > sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST PASSED" sim.log

//--- verilog/softmax_consts.svh
//////////////////////////////
// Widths sized for 4-bit elements and rows of at most 16 entries
// Changing SM_ELEM_W needs SM_EXP_W and SM_SUM_W to follow
//////////////////////////////
`ifndef SOFTMAX_CONSTS_SVH
`define SOFTMAX_CONSTS_SVH

// Element and exponential
`define SM_ELEM_W   4
`define SM_EXP_W    16
// Row sum holds 16 * 2**15
`define SM_SUM_W    20
// Probability is 1.12 fixed point, 4096 means one
`define SM_FRAC_W   12
`define SM_PROB_W   13
// Dividend is the exponential shifted up by the fraction bits
`define SM_DIVD_W   (`SM_EXP_W + `SM_FRAC_W)
// Row and run limits
`define SM_MAX_LEN  16
`define SM_LEN_W    5
`define SM_MAX_ROWS 16
`define SM_ROW_W    5

`endif

//--- verilog/softmax_ctrl_pkg.sv
//////////////////////////////
// FSM encodings for the row loop and the emitter
//////////////////////////////
`default_nettype none

package softmax_ctrl_pkg;

  // Top row loop
  typedef enum logic [1:0] {
    top_idle,
    top_load,
    top_emit
  } top_state_t;

  // Emitter, one pass per element
  typedef enum logic [1:0] {
    emit_idle,
    emit_read,
    emit_divide,
    emit_step
  } emit_state_t;

endpackage

`default_nettype wire

//--- verilog/softmax_data_pkg.sv
//////////////////////////////
// Data types only, widths come from the consts header
//////////////////////////////
`default_nettype none

`include "softmax_consts.svh"

package softmax_data_pkg;

  // Raw input element, unsigned
  typedef logic [`SM_ELEM_W-1:0] elem_t;
  // 2 ** element
  typedef logic [`SM_EXP_W-1:0] exp_t;
  // Sum of one row of exponentials
  typedef logic [`SM_SUM_W-1:0] sum_t;
  // Result probability, 12 fraction bits
  typedef logic [`SM_PROB_W-1:0] prob_t;
  // Row length or element index
  typedef logic [`SM_LEN_W-1:0] len_t;
  // Row count or row index
  typedef logic [`SM_ROW_W-1:0] row_t;

endpackage

`default_nettype wire

//--- verilog/softmax_divider.sv
//////////////////////////////
// Needs dividend <= divisor * 4096; quotient holds only 13 bits
// div_done 27 cycles after div_start, one division at a time
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "softmax_consts.svh"

module softmax_divider (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     div_start,
  input  wire [`SM_DIVD_W-1:0]    dividend,
  input  softmax_data_pkg::sum_t  divisor,
  output logic                    div_done,
  output softmax_data_pkg::prob_t quotient
);

  import softmax_data_pkg::*;

  // Top two dividend bits never reach the divisor, taken straight into the remainder
  localparam int SH_W  = `SM_DIVD_W - 2;
  localparam int CNT_W = $clog2(SH_W + 1);

  logic             busy;
  logic [CNT_W-1:0] cnt;
  sum_t             rem;
  sum_t             div_q;
  logic [SH_W-1:0]  shreg;

  logic [`SM_SUM_W:0] partial;
  logic [`SM_SUM_W:0] diff;
  logic               q_bit;

  // One restoring step
  assign partial = {rem, shreg[SH_W-1]};
  assign diff    = partial - {1'b0, div_q};
  assign q_bit   = ~diff[`SM_SUM_W];

  //////////////////////////////
  // Step counter
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      cnt      <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(SH_W);
      end else if (busy) begin
        cnt <= cnt - CNT_W'(1);
        // Last step
        if (cnt == CNT_W'(1)) begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  // Datapath, quotient held after done
  always_ff @(posedge CLK) begin
    if (div_start) begin
      rem      <= sum_t'(dividend[`SM_DIVD_W-1 -: 2]);
      shreg    <= dividend[SH_W-1:0];
      div_q    <= divisor;
      quotient <= '0;
    end else if (busy) begin
      rem      <= q_bit ? diff[`SM_SUM_W-1:0] : partial[`SM_SUM_W-1:0];
      shreg    <= shreg << 1;
      // High quotient bits are always zero and drop out
      quotient <= {quotient[`SM_PROB_W-2:0], q_bit};
    end
  end

  // Row sum is never zero once a row is loaded
  a_div_nonzero : assert property (@(posedge CLK) disable iff (RST)
    div_start |-> (divisor != '0));

  // Emitter waits for div_done before the next launch
  a_div_free : assert property (@(posedge CLK) disable iff (RST)
    div_start |-> !busy);

endmodule

`default_nettype wire

//--- verilog/softmax_emitter.sv
//////////////////////////////
// length and exp_sum must stay stable until out_last
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "softmax_consts.svh"

module softmax_emitter (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     emit_start,
  input  softmax_data_pkg::len_t  length,
  input  softmax_data_pkg::sum_t  exp_sum,
  input  softmax_data_pkg::exp_t  rd_data,
  output softmax_data_pkg::len_t  rd_addr,
  output logic                    div_start,
  output logic [`SM_DIVD_W-1:0]   dividend,
  output softmax_data_pkg::sum_t  divisor,
  input  wire                     div_done,
  input  softmax_data_pkg::prob_t quotient,
  output logic                    out_valid,
  output softmax_data_pkg::prob_t out_data,
  output logic                    out_last
);

  import softmax_data_pkg::*;
  import softmax_ctrl_pkg::*;

  emit_state_t state;
  len_t        idx;
  logic        last_idx;

  assign rd_addr  = idx;
  assign divisor  = exp_sum;
  assign last_idx = (idx == length - len_t'(1));

  //////////////////////////////
  // Per element sequencing
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= emit_idle;
      idx       <= '0;
      div_start <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      div_start <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      case (state)
        emit_idle: begin
          if (emit_start) begin
            idx   <= '0;
            state <= emit_read;
          end
        end
        // Exponential latched below, launch division
        emit_read: begin
          div_start <= 1'b1;
          state     <= emit_divide;
        end
        emit_divide: begin
          if (div_done) begin
            out_valid <= 1'b1;
            out_last  <= last_idx;
            state     <= emit_step;
          end
        end
        // Result on the outputs this cycle
        emit_step: begin
          if (last_idx) begin
            state <= emit_idle;
          end else begin
            idx   <= idx + len_t'(1);
            state <= emit_read;
          end
        end
        default: state <= emit_idle;
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge CLK) begin
    if (state == emit_read) begin
      dividend <= {rd_data, {`SM_FRAC_W{1'b0}}};
    end
    if (div_done) begin
      out_data <= quotient;
    end
  end

  // Division results arrive only while a launch is pending
  a_done_in_divide : assert property (@(posedge CLK) disable iff (RST)
    div_done |-> (state == emit_divide));

endmodule

`default_nettype wire

//--- verilog/softmax_exp_loader.sv
//////////////////////////////
// Row store has no reset; contents valid only after row_loaded
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "softmax_consts.svh"

module softmax_exp_loader (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     load_en,
  input  wire                     first,
  input  softmax_data_pkg::elem_t data_in,
  input  softmax_data_pkg::len_t  length,
  input  softmax_data_pkg::len_t  rd_addr,
  output softmax_data_pkg::exp_t  rd_data,
  output softmax_data_pkg::sum_t  exp_sum,
  output logic                    row_loaded
);

  import softmax_data_pkg::*;

  localparam int ADDR_W = $clog2(`SM_MAX_LEN);

  // Row store of exponentials
  exp_t mem [`SM_MAX_LEN];

  len_t idx;
  len_t wr_idx;
  len_t cnt_next;
  exp_t exp_val;
  sum_t sum_base;

  // 2 ** element, a single set bit
  assign exp_val = exp_t'(1) << data_in;

  // First element restarts index and sum
  assign wr_idx   = first ? len_t'(0) : idx;
  assign cnt_next = wr_idx + len_t'(1);
  assign sum_base = first ? sum_t'(0) : exp_sum;

  //////////////////////////////
  // Count and accumulate
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      idx        <= '0;
      exp_sum    <= '0;
      row_loaded <= 1'b0;
    end else begin
      row_loaded <= 1'b0;
      if (load_en) begin
        idx     <= cnt_next;
        exp_sum <= sum_base + sum_t'(exp_val);
        // Pulse once the row is complete
        row_loaded <= (cnt_next == length);
      end
    end
  end

  // Store write
  always_ff @(posedge CLK) begin
    if (load_en) begin
      mem[wr_idx[ADDR_W-1:0]] <= exp_val;
    end
  end

  // Combinational read for the emitter
  assign rd_data = mem[rd_addr[ADDR_W-1:0]];

  // Source must not send more than length elements per row
  a_wr_in_row : assert property (@(posedge CLK) disable iff (RST)
    load_en |-> (wr_idx < length));

endmodule

`default_nettype wire

//--- verilog/vector_softmax.sv
//////////////////////////////
// No back-pressure; next row only after data_out_vector_enable
// size and length of zero not supported
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "softmax_consts.svh"

module vector_softmax (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     start,
  input  softmax_data_pkg::row_t  size_in,
  input  softmax_data_pkg::len_t  length_in,
  input  softmax_data_pkg::elem_t data_in,
  input  wire                     data_in_vector_enable,
  input  wire                     data_in_scalar_enable,
  output softmax_data_pkg::prob_t data_out,
  output logic                    data_out_scalar_enable,
  output logic                    data_out_vector_enable,
  output logic                    ready
);

  import softmax_data_pkg::*;
  import softmax_ctrl_pkg::*;

  top_state_t state;
  row_t       size_q;
  len_t       length_q;
  row_t       row_cnt;
  logic       emit_start;
  logic       load_en;
  logic       last_row;

  // Loader links
  logic row_loaded;
  sum_t exp_sum;
  len_t rd_addr;
  exp_t rd_data;

  // Divider links
  logic                  div_start;
  logic [`SM_DIVD_W-1:0] dividend;
  sum_t                  divisor;
  logic                  div_done;
  prob_t                 quotient;

  // Emitter results
  logic  out_valid;
  logic  out_last;
  prob_t out_data;

  // Input strobes count only while loading
  assign load_en  = (state == top_load) &&
                    (data_in_vector_enable || data_in_scalar_enable);
  assign last_row = (row_cnt == size_q - row_t'(1));

  // Output strobes straight from the emitter
  assign data_out               = out_data;
  assign data_out_scalar_enable = out_valid;
  assign data_out_vector_enable = out_valid && out_last;
  assign ready                  = out_valid && out_last && last_row;

  //////////////////////////////
  // Row loop
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= top_idle;
      size_q     <= '0;
      length_q   <= '0;
      row_cnt    <= '0;
      emit_start <= 1'b0;
    end else begin
      emit_start <= 1'b0;
      case (state)
        top_idle: begin
          if (start) begin
            size_q   <= size_in;
            length_q <= length_in;
            row_cnt  <= '0;
            state    <= top_load;
          end
        end
        top_load: begin
          if (row_loaded) begin
            emit_start <= 1'b1;
            state      <= top_emit;
          end
        end
        // Wait for the row's last result
        top_emit: begin
          if (out_valid && out_last) begin
            if (last_row) begin
              state <= top_idle;
            end else begin
              row_cnt <= row_cnt + row_t'(1);
              state   <= top_load;
            end
          end
        end
        default: state <= top_idle;
      endcase
    end
  end

  softmax_exp_loader u_loader (
    .CLK        (CLK),
    .RST        (RST),
    .load_en    (load_en),
    .first      (data_in_vector_enable),
    .data_in    (data_in),
    .length     (length_q),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .exp_sum    (exp_sum),
    .row_loaded (row_loaded)
  );

  softmax_divider u_div (
    .CLK       (CLK),
    .RST       (RST),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_done  (div_done),
    .quotient  (quotient)
  );

  softmax_emitter u_emit (
    .CLK        (CLK),
    .RST        (RST),
    .emit_start (emit_start),
    .length     (length_q),
    .exp_sum    (exp_sum),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .div_start  (div_start),
    .dividend   (dividend),
    .divisor    (divisor),
    .div_done   (div_done),
    .quotient   (quotient),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last)
  );

endmodule

`default_nettype wire
